// ==== Makefile ====
SIM       = verilator
TOP       = lc3CoreTb
FLIST     = flist.f
SIMFLAGS  = --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps -Wall
BUILD     = obj_dir
LOG       = sim.log
FAILMSG   = TEST FAIL

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then exit 1; fi

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== flist.f ====
hw/lc3IsaPkg.sv
hw/lc3CtrlPkg.sv
hw/lc3RegFile.sv
hw/lc3Control.sv
hw/lc3Datapath.sv
hw/lc3Core.sv
verif/lc3Core_chk.sv
verif/lc3CoreTb.sv

// ==== hw/lc3Control.sv ====
/*
 * Multi-cycle control FSM of the core.
 * Sequences fetch, decode and execute and drives every load enable, bus
 * gate, mux select and SRAM strobe of the datapath.
 */
module lc3Control
	import lc3IsaPkg::*, lc3CtrlPkg::*;
(
	input  logic      Clk,
	input  logic      rst,
	input  logic      Run,
	input  logic      Continue,
	input  opcode_e   opcode,
	input  logic      ir5,
	input  logic      ben,
	output logic      ldMar,
	output logic      ldMdr,
	output logic      ldIr,
	output logic      ldBen,
	output logic      ldCc,
	output logic      ldReg,
	output logic      ldPc,
	output logic      ldLed,
	output logic      gatePc,
	output logic      gateMdr,
	output logic      gateAlu,
	output logic      gateMarMux,
	output pcSel_e    pcMux,
	output logic      drMux,
	output logic      sr1Mux,
	output logic      sr2Mux,
	output logic      addr1Mux,
	output addr2Sel_e addr2Mux,
	output aluOp_e    aluK,
	output logic      memOeN,
	output logic      memWeN,
	output logic      halted
);

	typedef enum logic [4:0] {
		stHalted, stFetchMar, stFetchRd1, stFetchRd2, stFetchIr, stDecode,
		stAdd, stAnd, stNot, stBrTest, stBrTaken, stJmp, stJsrLink, stJsrJump,
		stLdrAddr, stLdrRd1, stLdrRd2, stLdrWb,
		stStrAddr, stStrData, stStrWr1, stStrWr2,
		stPause1, stPause2
	} state_e;

	state_e state;
	state_e nextState;

	always_ff @(posedge Clk)
	begin
		if (rst)
			state <= stHalted;
		else
			state <= nextState;
	end

	// ------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------
	always_comb
	begin
		nextState = state;	// Hold by default
		case (state)
			stHalted:   if (Run) nextState = stFetchMar;
			stFetchMar: nextState = stFetchRd1;
			stFetchRd1: nextState = stFetchRd2;	// Two read states, fixed SRAM latency
			stFetchRd2: nextState = stFetchIr;
			stFetchIr:  nextState = stDecode;
			stDecode:
				case (opcode)
					OpAdd:   nextState = stAdd;
					OpAnd:   nextState = stAnd;
					OpNot:   nextState = stNot;
					OpBr:    nextState = stBrTest;
					OpJmp:   nextState = stJmp;
					OpJsr:   nextState = stJsrLink;
					OpLdr:   nextState = stLdrAddr;
					OpStr:   nextState = stStrAddr;
					OpPause: nextState = stPause1;
					default: nextState = stHalted;	// Illegal opcode stops the core
				endcase
			stBrTest:   nextState = ben ? stBrTaken : stFetchMar;
			stJsrLink:  nextState = stJsrJump;
			stLdrAddr:  nextState = stLdrRd1;
			stLdrRd1:   nextState = stLdrRd2;
			stLdrRd2:   nextState = stLdrWb;
			stStrAddr:  nextState = stStrData;
			stStrData:  nextState = stStrWr1;
			stStrWr1:   nextState = stStrWr2;
			stPause1:   if (Continue) nextState = stPause2;	// Wait for press
			stPause2:   if (!Continue) nextState = stFetchMar;	// Then release
			stAdd, stAnd, stNot, stBrTaken, stJmp, stJsrJump, stLdrWb, stStrWr2:
				nextState = stFetchMar;
			default:    nextState = stHalted;
		endcase
	end

	// ------------------------------------------------------------------
	// Output decode, defaults first
	// ------------------------------------------------------------------
	always_comb
	begin
		ldMar = 1'b0;
		ldMdr = 1'b0;
		ldIr = 1'b0;
		ldBen = 1'b0;
		ldCc = 1'b0;
		ldReg = 1'b0;
		ldPc = 1'b0;
		ldLed = 1'b0;
		gatePc = 1'b0;
		gateMdr = 1'b0;
		gateAlu = 1'b0;
		gateMarMux = 1'b0;
		pcMux = PcPlusOne;
		drMux = 1'b0;	// IR[11:9]
		sr1Mux = 1'b0;	// IR[11:9]
		sr2Mux = 1'b0;	// SR2 register
		addr1Mux = 1'b0;	// PC
		addr2Mux = Addr2Zero;
		aluK = AluAdd;
		memOeN = 1'b1;
		memWeN = 1'b1;

		case (state)
			stFetchMar:
			begin
				gatePc = 1'b1;	// MAR <- PC
				ldMar = 1'b1;
				ldPc = 1'b1;	// PC <- PC + 1
			end
			stFetchRd1, stLdrRd1:
				memOeN = 1'b0;
			stFetchRd2, stLdrRd2:
			begin
				memOeN = 1'b0;
				ldMdr = 1'b1;	// MDR <- M[MAR]
			end
			stFetchIr:
			begin
				gateMdr = 1'b1;
				ldIr = 1'b1;
			end
			stDecode:
				ldBen = 1'b1;
			stAdd, stAnd, stNot:
			begin
				sr1Mux = 1'b1;	// IR[8:6]
				sr2Mux = ir5;	// Immediate form
				gateAlu = 1'b1;
				ldReg = 1'b1;
				ldCc = 1'b1;
				if (state == stAnd)
					aluK = AluAnd;
				else if (state == stNot)
					aluK = AluNot;
			end
			stBrTaken:
			begin
				addr2Mux = Addr2Offset9;	// PC + off9
				pcMux = PcAdder;
				ldPc = 1'b1;
			end
			stJmp:
			begin
				sr1Mux = 1'b1;	// BaseR
				aluK = AluPassA;
				gateAlu = 1'b1;
				pcMux = PcBus;
				ldPc = 1'b1;
			end
			stJsrLink:
			begin
				gatePc = 1'b1;	// R7 <- PC
				drMux = 1'b1;
				ldReg = 1'b1;
			end
			stJsrJump:
			begin
				addr2Mux = Addr2Offset11;	// PC + off11
				pcMux = PcAdder;
				ldPc = 1'b1;
			end
			stLdrAddr, stStrAddr:
			begin
				sr1Mux = 1'b1;	// MAR <- BaseR + off6
				addr1Mux = 1'b1;
				addr2Mux = Addr2Offset6;
				gateMarMux = 1'b1;
				ldMar = 1'b1;
			end
			stLdrWb:
			begin
				gateMdr = 1'b1;	// DR <- MDR, set CC
				ldReg = 1'b1;
				ldCc = 1'b1;
			end
			stStrData:
			begin
				aluK = AluPassA;	// MDR <- SR through the ALU
				gateAlu = 1'b1;
				ldMdr = 1'b1;
			end
			stStrWr1, stStrWr2:
				memWeN = 1'b0;
			stPause1, stPause2:
				ldLed = 1'b1;
			default: ;
		endcase
	end

	assign halted = (state == stHalted);

endmodule

// ==== hw/lc3Core.sv ====
/*
 * Top level of the LC-3 style core. Joins the control FSM and the
 * datapath. The SRAM sits outside on memAddr, memWrData and memRdData.
 */
module lc3Core
	import lc3IsaPkg::*, lc3CtrlPkg::*;
#(
	parameter logic [15:0] ResetPc = 16'h0000
)
(
	input  logic        Clk,
	input  logic        rst,
	input  logic        Run,
	input  logic        Continue,
	input  logic [15:0] memRdData,
	output logic [15:0] memAddr,
	output logic [15:0] memWrData,
	output logic        memOeN,	// Active low read enable
	output logic        memWeN,	// Active low write enable
	output logic [11:0] led,
	output logic        halted
);

	logic      ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
	logic      gatePc, gateMdr, gateAlu, gateMarMux;
	logic      drMux, sr1Mux, sr2Mux, addr1Mux;
	pcSel_e    pcMux;
	addr2Sel_e addr2Mux;
	aluOp_e    aluK;
	opcode_e   opcode;
	logic      ir5;
	logic      ben;

	lc3Control control (
		.Clk(Clk), .rst(rst), .Run(Run), .Continue(Continue),
		.opcode(opcode), .ir5(ir5), .ben(ben),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldBen(ldBen),
		.ldCc(ldCc), .ldReg(ldReg), .ldPc(ldPc), .ldLed(ldLed),
		.gatePc(gatePc), .gateMdr(gateMdr), .gateAlu(gateAlu), .gateMarMux(gateMarMux),
		.pcMux(pcMux), .drMux(drMux), .sr1Mux(sr1Mux), .sr2Mux(sr2Mux),
		.addr1Mux(addr1Mux), .addr2Mux(addr2Mux), .aluK(aluK),
		.memOeN(memOeN), .memWeN(memWeN), .halted(halted)
	);

	lc3Datapath #(.ResetPc(ResetPc)) datapath (
		.Clk(Clk), .rst(rst),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldBen(ldBen),
		.ldCc(ldCc), .ldReg(ldReg), .ldPc(ldPc), .ldLed(ldLed),
		.gatePc(gatePc), .gateMdr(gateMdr), .gateAlu(gateAlu), .gateMarMux(gateMarMux),
		.pcMux(pcMux), .drMux(drMux), .sr1Mux(sr1Mux), .sr2Mux(sr2Mux),
		.addr1Mux(addr1Mux), .addr2Mux(addr2Mux), .aluK(aluK),
		.memOeN(memOeN), .memRdData(memRdData),
		.memAddr(memAddr), .memWrData(memWrData),
		.opcode(opcode), .ir5(ir5), .ben(ben), .led(led)
	);

endmodule

// ==== hw/lc3CtrlPkg.sv ====
/*
 * Control encodings shared by the control FSM and the datapath.
 * ALU function, PC input source and second address-adder operand.
 */
package lc3CtrlPkg;

	// ------------------------------------------------------------------
	// ALU function, driven on aluK
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		AluAdd   = 2'b00,
		AluAnd   = 2'b01,
		AluNot   = 2'b10,
		AluPassA = 2'b11	// SR1 straight through, used by STR and JMP
	} aluOp_e;

	// ------------------------------------------------------------------
	// PC input mux
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		PcPlusOne = 2'b00,	// Sequential fetch
		PcBus     = 2'b01,	// JMP target off the bus
		PcAdder   = 2'b10	// Branch and JSR targets
	} pcSel_e;

	// ------------------------------------------------------------------
	// Second operand of the address adder
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		Addr2Zero     = 2'b00,
		Addr2Offset6  = 2'b01,
		Addr2Offset9  = 2'b10,
		Addr2Offset11 = 2'b11
	} addr2Sel_e;

endpackage

// ==== hw/lc3Datapath.sv ====
/*
 * Datapath of the core: PC, MAR, MDR, IR and LED registers, the ALU,
 * the address adder and the single internal bus. Driven by lc3Control.
 */
module lc3Datapath
	import lc3IsaPkg::*, lc3CtrlPkg::*;
#(
	parameter logic [15:0] ResetPc = 16'h0000
)
(
	input  logic        Clk,
	input  logic        rst,
	input  logic        ldMar,
	input  logic        ldMdr,
	input  logic        ldIr,
	input  logic        ldBen,
	input  logic        ldCc,
	input  logic        ldReg,
	input  logic        ldPc,
	input  logic        ldLed,
	input  logic        gatePc,
	input  logic        gateMdr,
	input  logic        gateAlu,
	input  logic        gateMarMux,
	input  pcSel_e      pcMux,
	input  logic        drMux,
	input  logic        sr1Mux,
	input  logic        sr2Mux,
	input  logic        addr1Mux,
	input  addr2Sel_e   addr2Mux,
	input  aluOp_e      aluK,
	input  logic        memOeN,
	input  logic [15:0] memRdData,
	output logic [15:0] memAddr,
	output logic [15:0] memWrData,
	output opcode_e     opcode,
	output logic        ir5,
	output logic        ben,
	output logic [11:0] led
);

	logic [15:0] pc;
	logic [15:0] mar;
	logic [15:0] mdr;
	instr_u      ir;
	logic [15:0] bus;
	logic [15:0] sr1Out;
	logic [15:0] sr2Out;
	logic [15:0] aluB;
	logic [15:0] aluOut;
	logic [15:0] addr1;
	logic [15:0] addr2;
	logic [15:0] adderOut;
	logic [15:0] pcNext;
	logic [15:0] mdrIn;

	lc3RegFile regFile (
		.Clk    (Clk),
		.rst    (rst),
		.ldReg  (ldReg),
		.ldCc   (ldCc),
		.ldBen  (ldBen),
		.drMux  (drMux),
		.sr1Mux (sr1Mux),
		.instr  (ir),
		.busIn  (bus),
		.sr1Out (sr1Out),
		.sr2Out (sr2Out),
		.ben    (ben)
	);

	// ------------------------------------------------------------------
	// Bus, ALU and address adder
	// ------------------------------------------------------------------
	assign bus = ({16{gatePc}} & pc) | ({16{gateMdr}} & mdr) |
		({16{gateAlu}} & aluOut) | ({16{gateMarMux}} & adderOut);	// One gate at a time

	assign aluB = sr2Mux ? {{11{ir.op.src2.imm5[4]}}, ir.op.src2.imm5} : sr2Out;

	always_comb
	begin
		case (aluK)
			AluAdd:  aluOut = sr1Out + aluB;
			AluAnd:  aluOut = sr1Out & aluB;
			AluNot:  aluOut = ~sr1Out;
			default: aluOut = sr1Out;	// Pass A
		endcase
	end

	assign addr1 = addr1Mux ? sr1Out : pc;	// BaseR or PC

	always_comb
	begin
		case (addr2Mux)
			Addr2Offset6:  addr2 = {{10{ir.ofs.f.base.offset6[5]}}, ir.ofs.f.base.offset6};
			Addr2Offset9:  addr2 = {{7{ir.ofs.f.pcRel9.offset9[8]}}, ir.ofs.f.pcRel9.offset9};
			Addr2Offset11: addr2 = {{5{ir.ofs.f.pcRel11.offset11[10]}},
				ir.ofs.f.pcRel11.offset11};
			default:       addr2 = 16'h0000;
		endcase
	end

	assign adderOut = addr1 + addr2;

	always_comb
	begin
		case (pcMux)
			PcBus:   pcNext = bus;
			PcAdder: pcNext = adderOut;
			default: pcNext = pc + 16'd1;
		endcase
	end

	assign mdrIn = memOeN ? bus : memRdData;	// SRAM only during read states

	// ------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			pc  <= ResetPc;
			led <= 12'h000;
		end
		else
		begin
			if (ldPc)
				pc <= pcNext;
			if (ldLed)
				led <= ir[11:0];	// Pause code
		end
	end

	always_ff @(posedge Clk)
	begin
		if (ldMar)
			mar <= bus;
		if (ldMdr)
			mdr <= mdrIn;
		if (ldIr)
			ir <= bus;
	end

	assign memAddr   = mar;
	assign memWrData = mdr;
	assign opcode    = ir.op.opcode;
	assign ir5       = ir.op.immFlag;

endmodule

// ==== hw/lc3IsaPkg.sv ====
/*
 * Instruction-set definitions for the LC-3 style core.
 * Holds the opcode names that control decodes and the union that reads
 * one instruction word in its operate form and its offset form.
 */
package lc3IsaPkg;

	// ------------------------------------------------------------------
	// Opcodes handled by the core, everything else halts
	// ------------------------------------------------------------------
	typedef enum logic [3:0] {
		OpBr    = 4'b0000,	// Conditional branch
		OpAdd   = 4'b0001,
		OpJsr   = 4'b0100,	// PC-relative form only
		OpAnd   = 4'b0101,
		OpLdr   = 4'b0110,	// Base plus offset6 load
		OpStr   = 4'b0111,	// Base plus offset6 store
		OpNot   = 4'b1001,
		OpJmp   = 4'b1100,
		OpPause = 4'b1101	// Show IR[11:0] on LEDs, wait for Continue
	} opcode_e;

	// ------------------------------------------------------------------
	// One 16-bit instruction word, read two ways
	// ------------------------------------------------------------------
	typedef union packed {
		struct packed {
			opcode_e    opcode;
			logic [2:0] dr;	// IR[11:9]
			logic [2:0] sr1;	// IR[8:6]
			logic       immFlag;	// IR[5], picks imm5 over sr2
			union packed {
				logic [4:0] imm5;
				struct packed {
					logic [1:0] pad;	// IR[4:3], zero in register form
					logic [2:0] sr2;
				} regForm;
			} src2;
		} op;	// ADD, AND, NOT
		struct packed {
			opcode_e opcode;
			union packed {
				struct packed {
					logic [2:0] drNzp;	// DR for LDR, SR for STR
					logic [2:0] baseR;
					logic [5:0] offset6;
				} base;
				struct packed {
					logic [2:0] nzp;	// Branch condition mask
					logic [8:0] offset9;
				} pcRel9;
				struct packed {
					logic        jsrFlag;	// IR[11], set for the PC-relative JSR
					logic [10:0] offset11;
				} pcRel11;
			} f;
		} ofs;	// BR, JSR, JMP, LDR, STR
	} instr_u;

endpackage

// ==== hw/lc3RegFile.sv ====
/*
 * Eight general registers with NZP condition codes and branch enable.
 * Register numbers are decoded here from the IR word the datapath passes in.
 */
module lc3RegFile
	import lc3IsaPkg::*;
(
	input  logic        Clk,
	input  logic        rst,
	input  logic        ldReg,
	input  logic        ldCc,
	input  logic        ldBen,
	input  logic        drMux,
	input  logic        sr1Mux,
	input  instr_u      instr,
	input  logic [15:0] busIn,
	output logic [15:0] sr1Out,
	output logic [15:0] sr2Out,
	output logic        ben
);

	logic [15:0] regs [8];
	logic [2:0]  drSel;
	logic [2:0]  sr1Sel;
	logic [2:0]  nzp;	// Condition codes, N in bit 2

	assign drSel  = drMux ? 3'd7 : instr.op.dr;	// R7 link for JSR
	assign sr1Sel = sr1Mux ? instr.op.sr1 : instr.op.dr;

	assign sr1Out = regs[sr1Sel];
	assign sr2Out = regs[instr.op.src2.regForm.sr2];

	always_ff @(posedge Clk)
	begin
		if (ldReg)
			regs[drSel] <= busIn;
	end

	// ------------------------------------------------------------------
	// Condition codes and branch enable
	// ------------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			nzp <= 3'b000;
			ben <= 1'b0;
		end
		else
		begin
			if (ldCc)
			begin
				if (busIn[15])
					nzp <= 3'b100;	// Negative
				else if (busIn == 16'h0000)
					nzp <= 3'b010;
				else
					nzp <= 3'b001;
			end
			if (ldBen)
				ben <= |(instr.ofs.f.pcRel9.nzp & nzp);	// Any mask bit that matches
		end
	end

endmodule

// ==== verif/lc3CoreTb.sv ====
/*
 * Testbench for the LC-3 style core. Loads the program image and the
 * expected store and LED events from the vector file, models the SRAM,
 * answers pause instructions on Continue and checks every store.
 */
module lc3CoreTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam string VecFile = "verif/lc3_vectors.txt";
	localparam int ProgTop = 'h100;	// Program image below this
	localparam int StoreBase = 'h100;	// Store count followed by addr/data pairs
	localparam int LedBase = 'h140;	// LED count followed by values
	localparam logic [16:0] EmptyWord = 17'h10000;	// Bit 16 set where the file wrote nothing

	logic        Clk;
	logic        rst;
	logic        Run;
	logic        Continue;
	logic [15:0] memRdData;
	logic [15:0] memAddr;
	logic [15:0] memWrData;
	logic        memOeN;
	logic        memWeN;
	logic [11:0] led;
	logic        halted;

	logic [16:0] vec [0:511];
	logic [15:0] sram [0:1023];
	logic [15:0] storeAddrQ [$];
	logic [15:0] storeDataQ [$];
	logic [11:0] ledQ [$];
	logic [31:0] rngState = 32'd89;
	int          cycleCount = 0;
	int          cycleLimit = 1000;	// Replaced once the vectors are read
	logic        lastWeN = 1'b1;
	logic        pausing = 1'b0;
	logic        doneRun;

	lc3Core #(.ResetPc(16'h0000)) uut (
		.Clk(Clk), .rst(rst), .Run(Run), .Continue(Continue),
		.memRdData(memRdData), .memAddr(memAddr), .memWrData(memWrData),
		.memOeN(memOeN), .memWeN(memWeN), .led(led), .halted(halted)
	);

	initial Clk = 1'b0;
	always #20 Clk = ~Clk;	// 40 ns period

	// ------------------------------------------------------------------
	// SRAM model driven by two-cycle strobes from the core
	// ------------------------------------------------------------------
	assign memRdData = memOeN ? 16'hxxxx : sram[memAddr[9:0]];

	always @(posedge Clk)
	begin
		if (!memWeN)
			sram[memAddr[9:0]] <= memWrData;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkVal(input logic [15:0] actual, input logic [15:0] expected,
		input string name);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual,
				expected);
			failRun("value mismatch");
		end
	endtask

	task automatic loadVectors();
		int i;
		int progWords;
		int storeCount;
		int ledCount;
		progWords = 0;
		for (i = 0; i < 512; i++)
			vec[i] = EmptyWord;
		$readmemh(VecFile, vec);
		for (i = 0; i < 1024; i++)
			sram[i] = 16'(i) ^ 16'hC3A5;	// Background follows the address
		for (i = 0; i < ProgTop; i++)
		begin
			if (!vec[i][16])
			begin
				sram[i] = vec[i][15:0];
				progWords++;
			end
		end
		if (vec[StoreBase][16] || vec[LedBase][16])
			failRun("vector file has no store or LED section");
		storeCount = int'(vec[StoreBase][15:0]);
		ledCount = int'(vec[LedBase][15:0]);
		for (i = 0; i < storeCount; i++)
		begin
			storeAddrQ.push_back(vec[StoreBase + 1 + 2 * i][15:0]);
			storeDataQ.push_back(vec[StoreBase + 2 + 2 * i][15:0]);
		end
		for (i = 0; i < ledCount; i++)
			ledQ.push_back(vec[LedBase + 1 + i][11:0]);
		cycleLimit = 10 * progWords + 20 * ledCount + 200;	// Margin covers reset
	endtask

	// ------------------------------------------------------------------
	// Pause handling by a press and release of Continue
	// ------------------------------------------------------------------
	task automatic servicePause();
		int hold;
		logic [11:0] expLed;
		pausing = 1'b1;
		@(negedge Clk);	// LED register loaded by now
		if (ledQ.size() == 0)
			failRun("pause reached with no LED value left to expect");
		else
		begin
			expLed = ledQ.pop_front();
			checkVal(16'(led), 16'(expLed), "led");
		end
		rngState = xorshift32(rngState);
		hold = int'(rngState[2:0]) + 1;	// 1 to 8 cycles
		repeat (hold)
		begin
			@(negedge Clk);
			checkVal(16'(uut.ldLed), 16'h0001, "ldLed before press");
		end
		@(posedge Clk);
		Continue <= 1'b1;
		rngState = xorshift32(rngState);
		hold = int'(rngState[2:0]) + 1;
		repeat (hold)
		begin
			@(negedge Clk);
			checkVal(16'(uut.ldLed), 16'h0001, "ldLed before release");
		end
		@(posedge Clk);
		Continue <= 1'b0;
		while (uut.ldLed)
			@(negedge Clk);
		pausing = 1'b0;
	endtask

	// Store, strobe and checker monitor at mid-cycle
	always @(negedge Clk)
	begin
		if (!rst)
		begin
			if (uut.chk.failCount != 0)
				failRun("bound assertion checker flagged the core");
			if (pausing && (!memOeN || !memWeN))
				failRun("memory strobe went active during a pause");
			if (!memWeN && lastWeN)	// Falling write strobe
			begin
				if (storeAddrQ.size() == 0)
					failRun($sformatf("unexpected store of %h to %h", memWrData, memAddr));
				else
				begin
					checkVal(memAddr, storeAddrQ.pop_front(), "memAddr");
					checkVal(memWrData, storeDataQ.pop_front(), "memWrData");
				end
			end
			lastWeN = memWeN;
		end
	end

	always @(posedge Clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
			failRun($sformatf("timeout, no halt after %0d cycles", cycleCount));
	end

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial
	begin
		rst = 1'b1;
		Run = 1'b0;
		Continue = 1'b0;
		doneRun = 1'b0;
		loadVectors();
		repeat (4) @(posedge Clk);
		rst <= 1'b0;
		repeat (3)
		begin
			@(negedge Clk);	// Idle after reset with Run still low
			checkVal(16'(halted), 16'h0001, "halted");
			checkVal(16'(memOeN), 16'h0001, "memOeN");
			checkVal(16'(memWeN), 16'h0001, "memWeN");
			checkVal(16'(led), 16'h0000, "led");
		end
		@(posedge Clk);
		Run <= 1'b1;
		@(posedge Clk);
		Run <= 1'b0;	// One-cycle press since a held Run restarts after halt
		while (!doneRun)
		begin
			@(negedge Clk);
			if (halted)
				doneRun = 1'b1;
			else if (uut.ldLed)
				servicePause();
		end
		repeat (10)
		begin
			@(negedge Clk);
			checkVal(16'(halted), 16'h0001, "halted after illegal opcode");
		end
		if (storeAddrQ.size() == 0 && ledQ.size() == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
			failRun($sformatf("halted with %0d stores and %0d LED values outstanding",
				storeAddrQ.size(), ledQ.size()));
	end

endmodule

// ==== verif/lc3Core_chk.sv ====
/*
 * Assertions on the SRAM strobes and the halted flag of lc3Core.
 * Bound into the core, no ports of its own beyond what it watches.
 */
module lc3CoreChk
(
	input logic Clk,
	input logic rst,
	input logic memOeN,
	input logic memWeN,
	input logic halted
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;	// Assertion failures so far

	// Read and write strobes never overlap
	assert property (@(posedge Clk) disable iff (rst) !(!memOeN && !memWeN))
	else
	begin
		failCount = failCount + 1;
		$error("memOeN and memWeN low together");
	end

	// Reset leaves the core halted with the SRAM idle
	assert property (@(posedge Clk) rst |=> (memOeN && memWeN && halted))
	else
	begin
		failCount = failCount + 1;
		$error("core not idle and halted after reset");
	end

	// Write strobe spans exactly two cycles
	assert property (@(posedge Clk) disable iff (rst) $fell(memWeN) |=> !memWeN ##1 memWeN)
	else
	begin
		failCount = failCount + 1;
		$error("memWeN low for other than two cycles");
	end

endmodule

bind lc3Core lc3CoreChk chk (.*);

// ==== verif/lc3_vectors.txt ====
// Read with $readmemh. @000 program image, @050 LDR source word,
// @100 store count then address/data pairs, @140 LED count then values
@000
5020 1028 1000 1000 1000 5260 1267 147D   // 00 R0 = 0040, R1 = 7, R2 = 4
1642 58C1 9AFF 5D70 7600 7801 7A02 7C03   // 08 ADD, AND, NOT, then STR
6210 1261 7204 DA5C 54A0 0401 14A8 0A01   // 10 LDR, pause A5C, BRz taken, BRnp not
14A2 0201 14A8 0C01 14BA 0801 14A8 0601   // 18 BRp taken, BRnz not, BRn taken, BRzp not
14BF 7405 4803 7407 0E04 14A8 7E06 14A3   // 20 branch marker, JSR to 26, return store
C1C0 D3C1 F025                            // 28 JMP R7, pause 3C1, illegal opcode
@050
1234                                      // LDR source word
@100
0008
0040 000B  0041 0003  0042 FFF4  0043 FFF0
0044 1235  0045 FFFB  0046 0023  0047 FFFE
@140
0002
0A5C 03C1
